//--- cpu6502_pkg.sv
// Shared types, ALU codes, register selects and status layout of the 6502 execute pipeline
package cpu6502_pkg;

    // One opcode byte, either raw or split into the aaa_bbb_cc fields of the 6502 map
    typedef union packed {
        logic [7:0] raw;                        // Byte as presented by the sequencer
        struct packed {
            logic [2:0] aaa;                    // Operation within a group
            logic [2:0] bbb;                    // Addressing mode or row
            logic [1:0] cc;                     // Instruction group
        } f;
    } opcode_u;

    typedef struct packed {
        opcode_u    opcode;
        logic [7:0] operand;                    // Immediate byte, don't care for implied ops
    } instr_t;

    typedef enum logic [1:0] {
        SEL_A = 2'd0,
        SEL_S = 2'd1,
        SEL_X = 2'd2,
        SEL_Y = 2'd3
    } reg_sel_e;

    typedef enum logic [3:0] {
        OP_OR  = 4'b1100,
        OP_AND = 4'b1101,
        OP_EOR = 4'b1110,
        OP_ADD = 4'b0011,
        OP_SUB = 4'b0111,
        OP_ROL = 4'b1011,
        OP_A   = 4'b1111                        // Pass A, used for right shifts
    } alu_op_e;

    // Processor status word, P bit order
    typedef struct packed {
        logic n;
        logic v;
        logic one5;                             // Always one
        logic one4;                             // Always one, B position
        logic d;
        logic i;
        logic z;
        logic c;
    } status_t;

    typedef struct packed {
        reg_sel_e   src_reg;                    // Register feeding ALU input A
        reg_sel_e   dst_reg;                    // Register written at retire
        logic       load_reg;                   // Instruction writes a register
        alu_op_e    op;
        logic       shift;                      // ASL, LSR, ROL, ROR
        logic       shift_right;                // LSR, ROR
        logic       rotate;                     // ROL, ROR
        logic       load_only;                  // LDA, LDX, LDY immediate
        logic       inc;                        // INX, INY
        logic       adc_sbc;
        logic       adc_bcd;                    // ADC, decimal carry when D set
        logic       compare;                    // CMP, CPX, CPY
        logic       clc;
        logic       sec;
        logic       cli;
        logic       sei;
        logic       clv;
        logic       cld;
        logic       sed;
        logic [7:0] operand;
    } ctrl_t;

    typedef struct packed {
        logic [7:0] result;                     // Raw ALU sum before BCD adjust
        logic       co;                         // Carry out, decimal carry included
        logic       hc;                         // Low nibble carry
        logic       av;                         // Binary overflow
        ctrl_t      ctrl;
        logic       adj_bcd;                    // ADC or SBC with D set
    } alu_out_t;

    typedef struct packed {
        logic       write;
        reg_sel_e   dst;
        logic [7:0] value;
        status_t    p;                          // Status after this instruction
    } retire_t;

    localparam status_t STATUS_RESET = '{
        n: 1'b0, v: 1'b0, one5: 1'b1, one4: 1'b1,
        d: 1'b0, i: 1'b0, z: 1'b0, c: 1'b0
    };

endpackage

//--- op_decode.sv
// Decode stage, turns opcode and immediate byte into a registered control word
module op_decode (
    input  logic                clk,
    input  logic                reset,
    input  cpu6502_pkg::instr_t instr,
    input  logic                instr_valid,
    output cpu6502_pkg::ctrl_t  ctrl,
    output logic                ctrl_valid
);
    import cpu6502_pkg::*;

    opcode_u ir;                                // Opcode under decode
    logic    supported;                         // Opcode is in the implemented set
    logic    flag_row;                          // x8 column, odd high nibble
    logic    shift_a;                           // Accumulator shift column
    ctrl_t   ctrl_next;

    assign ir       = instr.opcode;
    assign flag_row = (ir.f.cc == 2'b00) && (ir.f.bbb == 3'b110);
    assign shift_a  = !ir.raw[7] && (ir.f.bbb == 3'b010) && (ir.f.cc == 2'b10);

    always_comb begin
        case (ir.raw)
            8'hA9, 8'hA2, 8'hA0,                        // LDA, LDX, LDY #
            8'h69, 8'hE9,                               // ADC, SBC #
            8'h09, 8'h29, 8'h49,                        // ORA, AND, EOR #
            8'hC9, 8'hE0, 8'hC0,                        // CMP, CPX, CPY #
            8'h0A, 8'h2A, 8'h4A, 8'h6A,                 // Shifts on A
            8'hAA, 8'h8A, 8'hA8, 8'h98, 8'hBA, 8'h9A,   // Transfers
            8'hE8, 8'hC8, 8'hCA, 8'h88,                 // INX, INY, DEX, DEY
            8'h18, 8'h38, 8'h58, 8'h78,
            8'hB8, 8'hD8, 8'hF8, 8'hEA:                 // Flag ops and NOP
                supported = 1'b1;
            default:
                supported = 1'b0;
        endcase
    end

    always_comb begin
        ctrl_next         = '0;                 // Writes nothing, keeps every flag
        ctrl_next.src_reg = SEL_A;
        ctrl_next.dst_reg = SEL_A;
        ctrl_next.op      = OP_ADD;
        ctrl_next.operand = instr.operand;
        if (supported) begin
            casez (ir.raw)
                8'b0??0_1010,                   // ASL, ROL, LSR, ROR A
                8'b0??0_1001,                   // ORA, AND, EOR, ADC
                8'b100?_10?0,                   // DEY, TXA, TYA, TXS
                8'b1010_???0,                   // LDY, LDX, TAY, TAX
                8'b1011_1010,                   // TSX
                8'b1?10_1001,                   // LDA, SBC
                8'b1??0_1000,                   // TAY, INY, INX
                8'b1100_1010:                   // DEX
                    ctrl_next.load_reg = 1'b1;
                default:
                    ctrl_next.load_reg = 1'b0;
            endcase
            casez (ir.raw)
                8'b1110_1000,                   // INX
                8'b1100_1010,                   // DEX
                8'b101?_??10:                   // LDX, TAX, TSX
                    ctrl_next.dst_reg = SEL_X;
                8'b1001_1010:                   // TXS
                    ctrl_next.dst_reg = SEL_S;
                8'b1?00_1000,                   // DEY, INY
                8'b1010_?000:                   // LDY, TAY
                    ctrl_next.dst_reg = SEL_Y;
                default:
                    ctrl_next.dst_reg = SEL_A;
            endcase
            casez (ir.raw)
                8'b1011_1010:                   // TSX
                    ctrl_next.src_reg = SEL_S;
                8'b100?_1?10,                   // TXA, TXS
                8'b1110_??00,                   // CPX, INX
                8'b1100_1010:                   // DEX
                    ctrl_next.src_reg = SEL_X;
                8'b1001_1000,                   // TYA
                8'b1100_??00,                   // CPY, INY
                8'b1?00_1000:                   // DEY
                    ctrl_next.src_reg = SEL_Y;
                default:
                    ctrl_next.src_reg = SEL_A;
            endcase
            casez (ir.raw)
                8'b00??_??10: ctrl_next.op = OP_ROL;    // ASL, ROL
                8'b01??_??10: ctrl_next.op = OP_A;      // LSR, ROR
                8'b1000_1000,                           // DEY
                8'b1100_1010,                           // DEX
                8'b11??_??01,                           // CMP, SBC
                8'b11?0_0?00: ctrl_next.op = OP_SUB;    // CPX, CPY
                8'b0???_??01:                           // Logic ops from aaa
                    if (ir.f.aaa != 3'b011) begin
                        ctrl_next.op = alu_op_e'({2'b11, ir.f.aaa[1:0]});
                    end
                default:      ctrl_next.op = OP_ADD;
            endcase
            ctrl_next.shift       = shift_a;
            ctrl_next.shift_right = shift_a & ir.raw[6];
            ctrl_next.rotate      = shift_a & ir.raw[5];
            ctrl_next.load_only   = ir.raw inside {8'hA9, 8'hA2, 8'hA0};
            ctrl_next.inc         = (ir.raw ==? 8'b11?0_1000);
            ctrl_next.adc_sbc     = (ir.f.cc == 2'b01) && (ir.f.aaa[1:0] == 2'b11);
            ctrl_next.adc_bcd     = (ir.f.cc == 2'b01) && (ir.f.aaa == 3'b011);
            ctrl_next.compare     = (ir.raw ==? 8'b11?0_0000) || (ir.raw == 8'hC9);
            if (flag_row) begin
                case (ir.f.aaa)                 // Row picks the flag, 100 is TYA
                    3'b000:  ctrl_next.clc = 1'b1;
                    3'b001:  ctrl_next.sec = 1'b1;
                    3'b010:  ctrl_next.cli = 1'b1;
                    3'b011:  ctrl_next.sei = 1'b1;
                    3'b101:  ctrl_next.clv = 1'b1;
                    3'b110:  ctrl_next.cld = 1'b1;
                    3'b111:  ctrl_next.sed = 1'b1;
                    default: ctrl_next.clc = 1'b0;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ctrl <= ctrl_next;                  // Held between strobes
        end
    end

endmodule

//--- alu_stage.sv
// ALU stage, reads bypassed operands, adds with decimal carry and registers the raw result
module alu_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu6502_pkg::ctrl_t    ctrl,
    input  logic                  ctrl_valid,
    input  logic [3:0][7:0]       regs_fwd,
    input  cpu6502_pkg::status_t  p_fwd,
    output cpu6502_pkg::alu_out_t alu_out,
    output logic                  alu_valid
);
    import cpu6502_pkg::*;

    logic       imm;                            // Operand byte feeds input B
    logic       bcd;                            // Decimal ADC in progress
    logic [7:0] ai;
    logic [7:0] bi;
    logic       ci;
    logic       adder_ci;                       // Carry into the low nibble
    logic [8:0] logic_out;                      // Bit 8 holds the shifted-out bit
    logic [7:0] b_term;                         // Second adder input
    logic [4:0] sum_l;
    logic [4:0] sum_h;
    logic       hc9;                            // Low digit above 9
    logic       co9;                            // High digit above 9
    logic       hc;
    alu_out_t   alu_next;

    assign imm = ctrl.load_only | ctrl.adc_sbc | ctrl.compare
               | (ctrl.op inside {OP_OR, OP_AND, OP_EOR});
    assign bcd = ctrl.adc_bcd & p_fwd.d;
    assign ai  = ctrl.load_only ? 8'h00 : regs_fwd[ctrl.src_reg];
    assign bi  = imm ? ctrl.operand : 8'h00;

    // Carry in, rotate first, then shift, compare, loads, immediates, inc
    always_comb begin
        if (ctrl.rotate) begin
            ci = p_fwd.c;
        end else if (ctrl.shift) begin
            ci = 1'b0;
        end else if (ctrl.compare) begin
            ci = 1'b1;                          // Compare is A + ~B + 1
        end else if (ctrl.load_only) begin
            ci = 1'b0;
        end else if (imm) begin
            ci = p_fwd.c;                       // ADC, SBC
        end else begin
            ci = ctrl.inc;                      // INX, INY, transfers, DEX, DEY
        end
    end

    always_comb begin
        case (ctrl.op[1:0])
            2'b00:   logic_out = {1'b0, ai | bi};
            2'b01:   logic_out = {1'b0, ai & bi};
            2'b10:   logic_out = {1'b0, ai ^ bi};
            default: logic_out = {1'b0, ai};
        endcase
        if (ctrl.shift_right) begin
            logic_out = {ai[0], ci, logic_out[7:1]};   // Bit 0 leaves through carry
        end
    end

    always_comb begin
        case (ctrl.op[3:2])
            2'b00:   b_term = bi;               // A + B
            2'b01:   b_term = ~bi;              // A - B
            2'b10:   b_term = logic_out[7:0];   // A + A, left shift
            default: b_term = 8'h00;            // Logic result passes through
        endcase
    end

    assign adder_ci = (ctrl.shift_right || ctrl.op[3:2] == 2'b11) ? 1'b0 : ci;
    assign sum_l    = {1'b0, logic_out[3:0]} + {1'b0, b_term[3:0]} + {4'b0000, adder_ci};
    assign hc9      = bcd & (sum_l[3:1] >= 3'd5);
    assign hc       = sum_l[4] | hc9;
    assign sum_h    = logic_out[8:4] + {1'b0, b_term[7:4]} + {4'b0000, hc};
    assign co9      = bcd & (sum_h[3:1] >= 3'd5);

    always_comb begin
        alu_next.result  = {sum_h[3:0], sum_l[3:0]};
        alu_next.co      = sum_h[4] | co9;
        alu_next.hc      = hc;
        alu_next.av      = logic_out[7] ^ b_term[7] ^ sum_h[4] ^ sum_h[3];  // Binary sum only
        alu_next.ctrl    = ctrl;
        alu_next.adj_bcd = ctrl.adc_sbc & p_fwd.d;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= ctrl_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_valid) begin
            alu_out <= alu_next;
        end
    end

endmodule

//--- bcd_writeback.sv
// Writeback stage, BCD adjust, flag update, register file and retire output
module bcd_writeback (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu6502_pkg::alu_out_t alu_out,
    input  logic                  alu_valid,
    output logic [3:0][7:0]       regs_fwd,
    output cpu6502_pkg::status_t  p_fwd,
    output cpu6502_pkg::retire_t  retire,
    output logic                  retire_valid
);
    import cpu6502_pkg::*;

    localparam logic [3:0][7:0] REGS_RESET = {8'h00, 8'h00, 8'hFF, 8'h00};  // Y X S A

    ctrl_t           cw;                        // Control word of the retiring op
    logic [3:0]      adj_l;
    logic [3:0]      adj_h;
    logic [7:0]      value;                     // Adjusted result
    logic            zn_upd;
    logic [3:0][7:0] regs;                      // A, S, X, Y
    status_t         p;

    assign cw = alu_out.ctrl;

    // Low digit, +6 on decimal carry for ADC, +10 on borrow for SBC
    always_comb begin
        casez ({alu_out.adj_bcd, cw.adc_bcd, alu_out.hc})
            3'b0??:  adj_l = 4'd0;
            3'b100:  adj_l = 4'd10;
            3'b111:  adj_l = 4'd6;
            default: adj_l = 4'd0;
        endcase
    end

    // High digit, same rule on the carry out
    always_comb begin
        casez ({alu_out.adj_bcd, cw.adc_bcd, alu_out.co})
            3'b0??:  adj_h = 4'd0;
            3'b100:  adj_h = 4'd10;
            3'b111:  adj_h = 4'd6;
            default: adj_h = 4'd0;
        endcase
    end

    assign value  = {alu_out.result[7:4] + adj_h, alu_out.result[3:0] + adj_l};
    assign zn_upd = (cw.load_reg && cw.dst_reg != SEL_S) || cw.compare;

    always_comb begin
        p_fwd = p;
        if (alu_valid) begin
            if (cw.adc_sbc || cw.shift || cw.compare) begin
                p_fwd.c = alu_out.co;           // Borrow shows as clear carry
            end else if (cw.sec) begin
                p_fwd.c = 1'b1;
            end else if (cw.clc) begin
                p_fwd.c = 1'b0;
            end
            if (zn_upd) begin
                p_fwd.z = (value == 8'h00);
                p_fwd.n = value[7];
            end
            if (cw.adc_sbc) begin
                p_fwd.v = alu_out.av;
            end else if (cw.clv) begin
                p_fwd.v = 1'b0;
            end
            if (cw.sei) begin
                p_fwd.i = 1'b1;
            end else if (cw.cli) begin
                p_fwd.i = 1'b0;
            end
            if (cw.sed) begin
                p_fwd.d = 1'b1;
            end else if (cw.cld) begin
                p_fwd.d = 1'b0;
            end
        end
    end

    always_comb begin
        regs_fwd = regs;                        // Bypass includes this retire
        if (alu_valid && cw.load_reg) begin
            regs_fwd[cw.dst_reg] = value;
        end
    end

    assign retire.write  = cw.load_reg;
    assign retire.dst    = cw.dst_reg;
    assign retire.value  = value;
    assign retire.p      = p_fwd;
    assign retire_valid  = alu_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= REGS_RESET;                 // S starts at FF
            p    <= STATUS_RESET;
        end else begin
            regs <= regs_fwd;
            p    <= p_fwd;
        end
    end

endmodule

//--- exec_core.sv
// Execute pipeline top, decode then ALU then BCD adjust with writeback
module exec_core (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu6502_pkg::instr_t  instr,
    input  logic                 instr_valid,
    output cpu6502_pkg::retire_t retire,
    output logic                 retire_valid
);
    import cpu6502_pkg::*;

    ctrl_t           ctrl;                      // Decode to ALU
    logic            ctrl_valid;
    alu_out_t        alu_out;                   // ALU to writeback
    logic            alu_valid;
    logic [3:0][7:0] regs_fwd;                  // Writeback bypass to ALU
    status_t         p_fwd;

    op_decode u_op_decode (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .ctrl_valid  (ctrl_valid)
    );

    alu_stage u_alu_stage (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid),
        .regs_fwd   (regs_fwd),
        .p_fwd      (p_fwd),
        .alu_out    (alu_out),
        .alu_valid  (alu_valid)
    );

    bcd_writeback u_bcd_writeback (
        .clk          (clk),
        .reset        (reset),
        .alu_out      (alu_out),
        .alu_valid    (alu_valid),
        .regs_fwd     (regs_fwd),
        .p_fwd        (p_fwd),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

endmodule

//--- exec_core_asserts.sv
// Pipeline timing and status invariants of the execute core, bound into the top
module exec_core_asserts (
    input logic                 clk,
    input logic                 reset,
    input logic                 instr_valid,
    input logic                 retire_valid,
    input cpu6502_pkg::status_t p
);
    timeunit 1ns;
    timeprecision 100ps;

    // Two register stages, writeback output is combinational
    a_retire_latency : assert property (@(posedge clk) disable iff (reset)
        instr_valid |-> ##2 retire_valid)
        else $error("retire_valid missing two cycles after instr_valid");

    a_retire_source : assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> $past(instr_valid, 2))
        else $error("retire_valid without a matching instr_valid");

    // Pipeline is empty right after reset
    a_quiet_after_reset : assert property (@(posedge clk)
        reset |=> !retire_valid ##1 !retire_valid ##1 !retire_valid)
        else $error("retire_valid too soon after reset");

    a_const_bits : assert property (@(posedge clk) disable iff (reset)
        p.one5 && p.one4)
        else $error("constant status bits not one");

endmodule

bind exec_core exec_core_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .retire_valid (retire_valid),
    .p            (p_fwd)
);

//--- tb_vectors.svh
// Stimulus table for the execute pipeline testbench, one instruction per row with expected retire
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: opcode, operand, write, dst, value, status after the instruction
// Value and dst are don't care on rows with write clear
localparam int NUM_VECTORS = 50;

localparam vec_t VECTORS [NUM_VECTORS] = '{
    '{8'hBA, 8'h00, 1'b1, SEL_X, 8'hFF, 8'hB0},    // TSX, S is FF out of reset
    '{8'hA9, 8'h00, 1'b1, SEL_A, 8'h00, 8'h32},    // LDA #00 sets Z
    '{8'hA2, 8'h80, 1'b1, SEL_X, 8'h80, 8'hB0},
    '{8'h9A, 8'h00, 1'b1, SEL_S, 8'h80, 8'hB0},    // TXS, flags untouched
    '{8'hA0, 8'h7F, 1'b1, SEL_Y, 8'h7F, 8'h30},
    '{8'h98, 8'h00, 1'b1, SEL_A, 8'h7F, 8'h30},    // TYA
    '{8'hAA, 8'h00, 1'b1, SEL_X, 8'h7F, 8'h30},    // TAX
    '{8'hBA, 8'h00, 1'b1, SEL_X, 8'h80, 8'hB0},    // TSX reads new S
    '{8'h38, 8'h00, 1'b0, SEL_A, 8'h00, 8'hB1},    // SEC
    '{8'hA9, 8'h50, 1'b1, SEL_A, 8'h50, 8'h31},
    '{8'h18, 8'h00, 1'b0, SEL_A, 8'h00, 8'h30},    // CLC
    '{8'h69, 8'h50, 1'b1, SEL_A, 8'hA0, 8'hF0},    // ADC overflow into N
    '{8'h38, 8'h00, 1'b0, SEL_A, 8'h00, 8'hF1},
    '{8'hE9, 8'hF0, 1'b1, SEL_A, 8'hB0, 8'hB0},    // SBC with borrow
    '{8'h69, 8'h70, 1'b1, SEL_A, 8'h20, 8'h31},    // ADC carry out
    '{8'hE9, 8'h21, 1'b1, SEL_A, 8'hFF, 8'hB0},
    '{8'hF8, 8'h00, 1'b0, SEL_A, 8'h00, 8'hB8},    // SED
    '{8'hA9, 8'h45, 1'b1, SEL_A, 8'h45, 8'h38},
    '{8'h69, 8'h38, 1'b1, SEL_A, 8'h83, 8'hF8},    // 45 + 38 = 83 decimal
    '{8'h38, 8'h00, 1'b0, SEL_A, 8'h00, 8'hF9},
    '{8'hA9, 8'h32, 1'b1, SEL_A, 8'h32, 8'h79},
    '{8'hE9, 8'h15, 1'b1, SEL_A, 8'h17, 8'h39},    // 32 - 15 = 17 decimal
    '{8'hE9, 8'h32, 1'b1, SEL_A, 8'h85, 8'hB8},    // 17 - 32 borrows, 85
    '{8'hD8, 8'h00, 1'b0, SEL_A, 8'h00, 8'hB0},    // CLD
    '{8'h69, 8'h05, 1'b1, SEL_A, 8'h8A, 8'hB0},    // Binary again
    '{8'h29, 8'h0F, 1'b1, SEL_A, 8'h0A, 8'h30},
    '{8'h09, 8'hF0, 1'b1, SEL_A, 8'hFA, 8'hB0},
    '{8'h49, 8'hFA, 1'b1, SEL_A, 8'h00, 8'h32},
    '{8'hC9, 8'h00, 1'b0, SEL_A, 8'h00, 8'h33},    // CMP equal
    '{8'hE0, 8'h81, 1'b0, SEL_A, 8'h00, 8'hB0},    // CPX below
    '{8'hC0, 8'h7F, 1'b0, SEL_A, 8'h00, 8'h33},
    '{8'hA9, 8'h81, 1'b1, SEL_A, 8'h81, 8'hB1},
    '{8'h0A, 8'h00, 1'b1, SEL_A, 8'h02, 8'h31},    // ASL
    '{8'h2A, 8'h00, 1'b1, SEL_A, 8'h05, 8'h30},    // ROL
    '{8'h4A, 8'h00, 1'b1, SEL_A, 8'h02, 8'h31},    // LSR
    '{8'h6A, 8'h00, 1'b1, SEL_A, 8'h81, 8'hB0},    // ROR
    '{8'hA2, 8'h00, 1'b1, SEL_X, 8'h00, 8'h32},
    '{8'hCA, 8'h00, 1'b1, SEL_X, 8'hFF, 8'hB0},    // DEX wraps
    '{8'hE8, 8'h00, 1'b1, SEL_X, 8'h00, 8'h32},
    '{8'hA0, 8'hFF, 1'b1, SEL_Y, 8'hFF, 8'hB0},
    '{8'hC8, 8'h00, 1'b1, SEL_Y, 8'h00, 8'h32},    // INY wraps
    '{8'h88, 8'h00, 1'b1, SEL_Y, 8'hFF, 8'hB0},
    '{8'h78, 8'h00, 1'b0, SEL_A, 8'h00, 8'hB4},    // SEI
    '{8'hA9, 8'h7F, 1'b1, SEL_A, 8'h7F, 8'h34},
    '{8'h69, 8'h01, 1'b1, SEL_A, 8'h80, 8'hF4},
    '{8'hB8, 8'h00, 1'b0, SEL_A, 8'h00, 8'hB4},    // CLV
    '{8'h58, 8'h00, 1'b0, SEL_A, 8'h00, 8'hB0},    // CLI
    '{8'hFF, 8'h00, 1'b0, SEL_A, 8'h00, 8'hB0},    // Unknown opcode
    '{8'hEA, 8'h00, 1'b0, SEL_A, 8'h00, 8'hB0},    // NOP
    '{8'hA8, 8'h00, 1'b1, SEL_Y, 8'h80, 8'hB0}     // TAY
};

`endif

//--- tb_exec_core.sv
// Testbench for the execute pipeline with table driven stimulus checked against a reference model
module tb_exec_core;
    timeunit 1ns;
    timeprecision 100ps;
    import cpu6502_pkg::*;

    typedef struct packed {
        logic [7:0] opcode;
        logic [7:0] operand;
        logic       write;
        reg_sel_e   dst;
        logic [7:0] value;
        logic [7:0] p;
    } vec_t;

    `include "tb_vectors.svh"

    localparam int LIMIT = NUM_VECTORS * 3 + 40;   // Cycles incl reset and drain

    logic     clk;
    logic     reset;
    instr_t   instr;
    logic     instr_valid;
    retire_t  retire;
    logic     retire_valid;

    retire_t    exp_q [$];                      // Expected retires in input order
    logic [7:0] m_regs [4];                     // Model register file indexed A S X Y
    status_t    m_p;
    int         mismatches;
    int         other_errors;
    int         cycles;
    int         seed;

    exec_core dut (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    // Digit-wise add with b inverted for SBC and {c, v, value} returned
    function automatic logic [9:0] decimal_sum(input logic [7:0] a, input logic [7:0] b,
                                               input logic cin, input logic dec,
                                               input logic sub);
        logic [4:0] lo;
        logic [4:0] hi;
        logic       hc;
        logic       co;
        logic       v;
        logic [3:0] dl;
        logic [3:0] dh;
        lo = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'b0000, cin};
        hc = lo[4] || (dec && !sub && lo[3:0] > 4'd9);  // Decimal carry for ADC only
        hi = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'b0000, hc};
        co = hi[4] || (dec && !sub && hi[3:0] > 4'd9);
        v  = (a[7] == b[7]) && (hi[3] != a[7]);         // Signed overflow
        dl = !dec ? 4'd0 : sub ? (hc ? 4'd0 : 4'd10) : (hc ? 4'd6 : 4'd0);
        dh = !dec ? 4'd0 : sub ? (co ? 4'd0 : 4'd10) : (co ? 4'd6 : 4'd0);
        return {co, v, hi[3:0] + dh, lo[3:0] + dl};
    endfunction

    task automatic run_model(input opcode_u op, input logic [7:0] imm, output retire_t r);
        status_t    p;
        reg_sel_e   dst;
        logic [7:0] a;
        logic [7:0] val;
        logic       wr;
        logic       cmp;
        p   = m_p;
        a   = m_regs[SEL_A];
        val = 8'h00;
        cmp = op.raw inside {8'hC9, 8'hE0, 8'hC0};
        wr  = op.raw inside {8'hA9, 8'hA2, 8'hA0, 8'hAA, 8'hA8, 8'h8A, 8'h9A, 8'h98,
                             8'hBA, 8'hE8, 8'hC8, 8'hCA, 8'h88, 8'h29, 8'h09, 8'h49,
                             8'h0A, 8'h2A, 8'h4A, 8'h6A, 8'h69, 8'hE9};
        case (op.raw)
            8'hA2, 8'hAA, 8'hBA, 8'hE8, 8'hCA: dst = SEL_X;
            8'hA0, 8'hA8, 8'hC8, 8'h88:        dst = SEL_Y;
            8'h9A:                             dst = SEL_S;
            default:                           dst = SEL_A;
        endcase
        case (op.raw)
            8'hA9, 8'hA2, 8'hA0: val = imm;
            8'hAA, 8'hA8:        val = a;
            8'h8A, 8'h9A:        val = m_regs[SEL_X];
            8'h98:               val = m_regs[SEL_Y];
            8'hBA:               val = m_regs[SEL_S];
            8'hE8:               val = m_regs[SEL_X] + 8'd1;
            8'hCA:               val = m_regs[SEL_X] - 8'd1;
            8'hC8:               val = m_regs[SEL_Y] + 8'd1;
            8'h88:               val = m_regs[SEL_Y] - 8'd1;
            8'h29:               val = a & imm;
            8'h09:               val = a | imm;
            8'h49:               val = a ^ imm;
            8'h0A:               {p.c, val} = {a, 1'b0};
            8'h2A:               {p.c, val} = {a, p.c};
            8'h4A:               {val, p.c} = {1'b0, a};
            8'h6A:               {val, p.c} = {p.c, a};
            8'h69:               {p.c, p.v, val} = decimal_sum(a, imm, p.c, p.d, 1'b0);
            8'hE9:               {p.c, p.v, val} = decimal_sum(a, ~imm, p.c, p.d, 1'b1);
            8'hC9, 8'hE0, 8'hC0: begin
                val = m_regs[op.raw == 8'hC9 ? SEL_A : op.raw == 8'hE0 ? SEL_X : SEL_Y];
                p.c = val >= imm;               // Register at least operand
                val = val - imm;
            end
            8'h18:               p.c = 1'b0;
            8'h38:               p.c = 1'b1;
            8'h58:               p.i = 1'b0;
            8'h78:               p.i = 1'b1;
            8'hB8:               p.v = 1'b0;
            8'hD8:               p.d = 1'b0;
            8'hF8:               p.d = 1'b1;
            default:             val = 8'h00;   // NOP and unknown opcodes
        endcase
        if ((wr && dst != SEL_S) || cmp) begin
            p.z = (val == 8'h00);
            p.n = val[7];
        end
        if (wr) begin
            m_regs[dst] = val;
        end
        m_p = p;
        r   = '{write: wr, dst: dst, value: val, p: p};
    endtask

    task automatic check_retire(input retire_t act, input retire_t exp);
        reg_sel_e act_dst;
        reg_sel_e exp_dst;
        act_dst = act.dst;
        exp_dst = exp.dst;
        if (act.write !== exp.write) begin
            mismatches++;
            $display("mismatch t=%0t retire.write act=%0b exp=%0b", $time, act.write, exp.write);
        end else if (exp.write && (act.dst !== exp.dst || act.value !== exp.value)) begin
            mismatches++;
            $display("mismatch t=%0t retire.dst/value act=%s/%02h exp=%s/%02h", $time,
                     act_dst.name(), act.value, exp_dst.name(), exp.value);
        end
    endtask

    task automatic check_status(input status_t act, input status_t exp);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch t=%0t retire.p act=%02h exp=%02h", $time, act, exp);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    endtask

    // Outputs settle after the edge so sample mid cycle
    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("retire seen at t=%0t with no instruction outstanding", $time);
            end else begin
                check_retire(retire, exp_q[0]);
                check_status(retire.p, exp_q[0].p);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            other_errors++;
            $display("timeout after %0d cycles, %0d retires never arrived", cycles, exp_q.size());
            print_counts();
            $display("test failed");
            $finish;
        end
    end

    initial begin
        retire_t model_r;
        retire_t table_r;
        int      gap;
        seed         = 32'h988d;
        mismatches   = 0;
        other_errors = 0;
        cycles       = 0;
        reset        = 1'b1;
        instr        = '0;
        instr_valid  = 1'b0;
        m_regs       = '{8'h00, 8'hFF, 8'h00, 8'h00};  // A S X Y
        m_p          = STATUS_RESET;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(posedge clk);
            #1;
            instr.opcode.raw = VECTORS[i].opcode;
            instr.operand    = VECTORS[i].operand;
            instr_valid      = 1'b1;
            table_r = '{write: VECTORS[i].write, dst: VECTORS[i].dst,
                        value: VECTORS[i].value, p: VECTORS[i].p};
            run_model(VECTORS[i].opcode, VECTORS[i].operand, model_r);
            if (model_r.write != table_r.write || model_r.p != table_r.p
                || (table_r.write && (model_r.dst != table_r.dst
                                      || model_r.value != table_r.value))) begin
                other_errors++;
                $display("table row %0d does not agree with the reference model", i);
            end
            exp_q.push_back(table_r);
            gap = $random(seed) & 1;            // Idle cycle between some rows
            if (gap != 0) begin
                @(posedge clk);
                #1 instr_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1 instr_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        print_counts();
        if (mismatches == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
cpu6502_pkg.sv
op_decode.sv
alu_stage.sv
bcd_writeback.sv
exec_core.sv
exec_core_asserts.sv
tb_exec_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
